// ==== armCtrl_settings.svh ====
`ifndef ARMCTRL_SETTINGS_SVH
`define ARMCTRL_SETTINGS_SVH

// ======================================================================
// Fixed ISA widths
// ======================================================================
`define INSTR_W 32   // Instruction word
`define FLAG_W  4    // NZCV
`define LANE_W  4    // Byte lanes per word
`define OFFS_W  2    // Byte offset inside a word

// Flag bit positions inside a flag word
`define FLAG_N 3
`define FLAG_Z 2
`define FLAG_C 1
`define FLAG_V 0

`endif

// ==== armCtrlPkg.sv ====
`default_nettype none

package armCtrlPkg;

  // Data-processing opcodes, ARM encoding order of bits 24:21
  typedef enum logic [3:0] {
    AND = 4'b0000,
    EOR = 4'b0001,
    SUB = 4'b0010,
    RSB = 4'b0011,
    ADD = 4'b0100,
    ADC = 4'b0101,
    SBC = 4'b0110,
    RSC = 4'b0111,
    TST = 4'b1000,   // Flags only
    TEQ = 4'b1001,   // Flags only
    CMP = 4'b1010,   // Flags only
    CMN = 4'b1011,   // Flags only
    ORR = 4'b1100,
    MOV = 4'b1101,
    BIC = 4'b1110,
    MVN = 4'b1111
  } aluOpT;

  // Top-level instruction class seen by decode
  typedef enum logic [2:0] {
    DP_REG = 3'd0,
    DP_IMM = 3'd1,
    LOAD   = 3'd2,
    STORE  = 3'd3,
    BRANCH = 3'd4,
    UNDEF  = 3'd5
  } instrClassT;

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    EQ, NE, CS, CC,
    MI, PL, VS, VC,
    HI, LS, GE, LT,
    GT, LE, AL,
    NV                 // Never executes here
  } condT;

endpackage

`default_nettype wire

// ==== ctrlBusIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// One stage's worth of control bits
interface ctrlBusIf;
  logic                    regWrite;
  logic                    memWrite;
  logic                    memtoReg;   // Result from memory
  logic                    branch;
  logic                    aluSrc;     // Immediate operand B
  logic [1:0]              flagWrite;  // [1] NZ, [0] CV
  armCtrlPkg::aluOpT       aluControl;
  logic                    byteAccess; // LDRB / STRB
  armCtrlPkg::condT        cond;
  armCtrlPkg::instrClassT  instrClass;

  modport src(output regWrite, memWrite, memtoReg, branch, aluSrc,
              flagWrite, aluControl, byteAccess, cond, instrClass);

  modport snk(input  regWrite, memWrite, memtoReg, branch, aluSrc,
              flagWrite, aluControl, byteAccess, cond, instrClass);
endinterface

`default_nettype wire

// ==== decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_settings.svh"

module decodeStage (
  input  logic [`INSTR_W-1:0] instrD,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  ctrlBusIf.src               bus
);

  logic [9:0]             controls;   // regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite, branch, aluOp
  logic                   regWriteRaw;
  logic                   aluOpSel;   // Opcode comes from bits 24:21
  logic                   sBit;
  logic                   lBit;
  logic                   uBit;
  logic                   isCmp;      // TST TEQ CMP CMN
  logic                   isArith;    // Writes C and V too
  logic                   isMem;
  armCtrlPkg::aluOpT      dpOp;
  armCtrlPkg::instrClassT instrClass;

  assign sBit  = instrD[20];
  assign lBit  = instrD[20];          // Same bit, load/store meaning
  assign uBit  = instrD[23];          // Offset added when set
  assign dpOp  = armCtrlPkg::aluOpT'(instrD[24:21]);
  assign isCmp = (instrD[24:23] == 2'b10);

  // ======================================================================
  // Instruction class
  // ======================================================================
  always_comb begin
    case (instrD[27:25])
      3'b000:  instrClass = armCtrlPkg::DP_REG;
      3'b001:  instrClass = armCtrlPkg::DP_IMM;
      3'b010:  instrClass = lBit ? armCtrlPkg::LOAD : armCtrlPkg::STORE;
      3'b011:  instrClass = instrD[4] ? armCtrlPkg::UNDEF     // Media space
                          : (lBit ? armCtrlPkg::LOAD : armCtrlPkg::STORE);
      3'b101:  instrClass = armCtrlPkg::BRANCH;
      default: instrClass = armCtrlPkg::UNDEF;                 // LDM, coproc, SWI
    endcase
    // Compare without S is the MRS/MSR/BX space
    if ((instrD[27:26] == 2'b00) && isCmp && !sBit)
      instrClass = armCtrlPkg::UNDEF;
    // Multiply and halfword transfers not supported
    if ((instrD[27:25] == 3'b000) && instrD[7] && instrD[4])
      instrClass = armCtrlPkg::UNDEF;
  end

  assign isMem = (instrClass == armCtrlPkg::LOAD) || (instrClass == armCtrlPkg::STORE);

  // ======================================================================
  // Main control word
  // ======================================================================
  always_comb begin
    case (instrClass)
      armCtrlPkg::DP_REG: controls = 10'b00_00_0_0_1_0_0_1;
      armCtrlPkg::DP_IMM: controls = 10'b00_00_1_0_1_0_0_1;
      armCtrlPkg::LOAD:   controls = {4'b00_01, ~instrD[25], 5'b1_1_0_0_0};  // Imm offset when I=0
      armCtrlPkg::STORE:  controls = {4'b10_01, ~instrD[25], 5'b0_0_1_0_0};  // Rd read as data
      armCtrlPkg::BRANCH: controls = 10'b01_10_1_0_0_0_1_0;                 // PC + imm24
      default:            controls = 10'b0;                                 // No writes
    endcase
  end

  assign {regSrcD, immSrcD, bus.aluSrc, bus.memtoReg, regWriteRaw,
          bus.memWrite, bus.branch, aluOpSel} = controls;

  assign bus.regWrite = regWriteRaw & ~(aluOpSel & isCmp);  // Compares set flags only

  // ======================================================================
  // ALU opcode and flag-write pair
  // ======================================================================
  always_comb begin
    isArith = dpOp inside {armCtrlPkg::SUB, armCtrlPkg::RSB, armCtrlPkg::ADD,
                           armCtrlPkg::ADC, armCtrlPkg::SBC, armCtrlPkg::RSC,
                           armCtrlPkg::CMP, armCtrlPkg::CMN};
    if (isMem) begin
      bus.aluControl = uBit ? armCtrlPkg::ADD : armCtrlPkg::SUB;  // Base +/- offset
      bus.flagWrite  = 2'b00;
    end else if (aluOpSel) begin
      bus.aluControl = dpOp;
      bus.flagWrite  = sBit ? {1'b1, isArith} : 2'b00;           // Logical keeps CV
    end else begin
      bus.aluControl = armCtrlPkg::ADD;                           // Branch target add
      bus.flagWrite  = 2'b00;
    end
  end

  assign bus.byteAccess = isMem & instrD[22];
  assign bus.cond       = armCtrlPkg::condT'(instrD[31:28]);
  assign bus.instrClass = instrClass;

endmodule

`default_nettype wire

// ==== condCheck.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_settings.svh"

module condCheck (
  input  armCtrlPkg::condT    cond,
  input  logic [`FLAG_W-1:0]  flags,      // Flags as seen in Execute
  input  logic [`FLAG_W-1:0]  aluFlags,
  input  logic [1:0]          flagWrite,
  output logic                condEx,
  output logic [`FLAG_W-1:0]  flagsNext
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign n = flags[`FLAG_N];
  assign z = flags[`FLAG_Z];
  assign c = flags[`FLAG_C];
  assign v = flags[`FLAG_V];

  always_comb begin
    case (cond)
      armCtrlPkg::EQ: condEx = z;
      armCtrlPkg::NE: condEx = ~z;
      armCtrlPkg::CS: condEx = c;
      armCtrlPkg::CC: condEx = ~c;
      armCtrlPkg::MI: condEx = n;
      armCtrlPkg::PL: condEx = ~n;
      armCtrlPkg::VS: condEx = v;
      armCtrlPkg::VC: condEx = ~v;
      armCtrlPkg::HI: condEx = c & ~z;           // Unsigned higher
      armCtrlPkg::LS: condEx = ~c | z;
      armCtrlPkg::GE: condEx = (n == v);         // Signed compares
      armCtrlPkg::LT: condEx = (n != v);
      armCtrlPkg::GT: condEx = ~z & (n == v);
      armCtrlPkg::LE: condEx = z | (n != v);
      armCtrlPkg::AL: condEx = 1'b1;
      default:        condEx = 1'b0;             // NV
    endcase
  end

  // Merge ALU flags field by field
  always_comb begin
    flagsNext = flags;
    if (flagWrite[1]) begin
      flagsNext[`FLAG_N] = aluFlags[`FLAG_N];
      flagsNext[`FLAG_Z] = aluFlags[`FLAG_Z];
    end
    if (flagWrite[0]) begin
      flagsNext[`FLAG_C] = aluFlags[`FLAG_C];
      flagsNext[`FLAG_V] = aluFlags[`FLAG_V];
    end
  end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_settings.svh"

module executeStage (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stall,
  input  logic                flushE,
  ctrlBusIf.snk               decBus,
  input  logic [`FLAG_W-1:0]  aluFlagsE,
  input  logic [`OFFS_W-1:0]  aluResultLowE,   // Byte address bits
  input  logic [`FLAG_W-1:0]  flagsM,          // Nearest pending flags
  input  logic                setFlagsM,
  input  logic [`FLAG_W-1:0]  flagsW,          // Committed
  input  logic                setFlagsW,
  output armCtrlPkg::aluOpT   aluControlE,
  output logic                aluSrcE,
  output logic                branchTakenE,
  output logic                regWriteE,
  output logic                memWriteE,
  output logic                memtoRegE,
  output logic                pcSrcE,
  output logic                setFlagsE,
  output logic [`FLAG_W-1:0]  flagsNextE,
  output logic [`LANE_W-1:0]  byteMaskE
);

  logic                   regWriteRawE;
  logic                   memWriteRawE;
  logic                   branchRawE;
  logic [1:0]             flagWriteE;
  logic                   byteAccessE;
  armCtrlPkg::condT       condE;
  armCtrlPkg::instrClassT instrClassE;
  logic [`FLAG_W-1:0]     flagsE;
  logic                   condExE;

  // ======================================================================
  // Decode/Execute register
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteRawE <= 1'b0;
      memWriteRawE <= 1'b0;
      memtoRegE    <= 1'b0;
      branchRawE   <= 1'b0;
      flagWriteE   <= 2'b00;
      instrClassE  <= armCtrlPkg::UNDEF;
      aluControlE  <= armCtrlPkg::AND;
      aluSrcE      <= 1'b0;
      byteAccessE  <= 1'b0;
      condE        <= armCtrlPkg::AL;
    end else if (!stall) begin                    // Stall wins over flush
      regWriteRawE <= decBus.regWrite & ~flushE;  // Bubble on flush
      memWriteRawE <= decBus.memWrite & ~flushE;
      memtoRegE    <= decBus.memtoReg & ~flushE;
      branchRawE   <= decBus.branch   & ~flushE;
      flagWriteE   <= flushE ? 2'b00 : decBus.flagWrite;
      instrClassE  <= flushE ? armCtrlPkg::UNDEF : decBus.instrClass;
      aluControlE  <= decBus.aluControl;
      aluSrcE      <= decBus.aluSrc;
      byteAccessE  <= decBus.byteAccess;
      condE        <= decBus.cond;
    end
  end

  // M pending first; flagsM already holds W pending when M sets none
  assign flagsE = (setFlagsM || setFlagsW) ? flagsM : flagsW;

  condCheck condCheck_inst (
    .cond      (condE),
    .flags     (flagsE),
    .aluFlags  (aluFlagsE),
    .flagWrite (flagWriteE),
    .condEx    (condExE),
    .flagsNext (flagsNextE)
  );

  // ======================================================================
  // Condition gating
  // ======================================================================
  assign regWriteE    = regWriteRawE & condExE;
  assign memWriteE    = memWriteRawE & condExE;
  assign branchTakenE = branchRawE   & condExE;
  assign pcSrcE       = branchTakenE;            // Only B redirects the PC here
  assign setFlagsE    = (flagWriteE != 2'b00) & condExE;

  // Store lanes, one-hot for STRB
  always_comb begin
    if ((instrClassE == armCtrlPkg::STORE) && memWriteE)
      byteMaskE = byteAccessE ? (`LANE_W'(1) << aluResultLowE) : {`LANE_W{1'b1}};
    else
      byteMaskE = '0;
  end

endmodule

`default_nettype wire

// ==== memWbStage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_settings.svh"

module memWbStage (
  input  logic                clk,
  input  logic                rstN,
  input  logic                stall,
  input  logic                regWriteE,
  input  logic                memWriteE,
  input  logic                memtoRegE,
  input  logic                pcSrcE,
  input  logic                setFlagsE,
  input  logic [`FLAG_W-1:0]  flagsNextE,
  input  logic [`LANE_W-1:0]  byteMaskE,
  output logic                memWriteM,
  output logic [`LANE_W-1:0]  byteMaskM,
  output logic                regWriteW,
  output logic                memtoRegW,
  output logic                pcSrcW,
  output logic [`FLAG_W-1:0]  flagsM,      // Pending flags for forwarding
  output logic                setFlagsM,
  output logic                setFlagsW,
  output logic [`FLAG_W-1:0]  flagsW       // Committed NZCV
);

  logic               regWriteM;
  logic               memtoRegM;
  logic               pcSrcM;
  logic [`FLAG_W-1:0] flagsNextM;
  logic [`FLAG_W-1:0] flagsNextW;

  // ======================================================================
  // Execute/Memory and Memory/Writeback registers
  // ======================================================================
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      pcSrcM    <= 1'b0;
      setFlagsM <= 1'b0;
      byteMaskM <= '0;
      regWriteW <= 1'b0;
      memtoRegW <= 1'b0;
      pcSrcW    <= 1'b0;
      setFlagsW <= 1'b0;
    end else if (!stall) begin
      regWriteM <= regWriteE;
      memWriteM <= memWriteE;
      memtoRegM <= memtoRegE;
      pcSrcM    <= pcSrcE;
      setFlagsM <= setFlagsE;
      byteMaskM <= byteMaskE;
      regWriteW <= regWriteM;
      memtoRegW <= memtoRegM;
      pcSrcW    <= pcSrcM;
      setFlagsW <= setFlagsM;
    end
  end

  // Flag payload rides along
  always_ff @(posedge clk) begin
    if (!stall) begin
      flagsNextM <= flagsNextE;
      flagsNextW <= flagsNextM;
    end
  end

  // Committed flags, loaded from the W bundle
  always_ff @(posedge clk) begin
    if (!rstN)
      flagsW <= '0;
    else if (!stall && setFlagsW)
      flagsW <= flagsNextW;
  end

  assign flagsM = setFlagsM ? flagsNextM : flagsNextW;  // Younger pending first

endmodule

`default_nettype wire

// ==== armController.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_settings.svh"

module armController (
  input  logic                clk,
  input  logic                rstN,
  // Hazard unit
  input  logic                stall,
  input  logic                flushE,
  // Datapath in
  input  logic [`INSTR_W-1:0] instrD,
  input  logic [`FLAG_W-1:0]  aluFlagsE,
  input  logic [`OFFS_W-1:0]  aluResultLowE,
  // Datapath out
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output armCtrlPkg::aluOpT   aluControlE,
  output logic                aluSrcE,
  output logic                branchTakenE,
  output logic                memWriteM,
  output logic [`LANE_W-1:0]  byteMaskM,
  output logic                regWriteW,
  output logic                memtoRegW,
  output logic                pcSrcW,
  output logic [`FLAG_W-1:0]  flagsW
);

  logic               regWriteE;
  logic               memWriteE;
  logic               memtoRegE;
  logic               pcSrcE;
  logic               setFlagsE;
  logic [`FLAG_W-1:0] flagsNextE;
  logic [`LANE_W-1:0] byteMaskE;
  logic [`FLAG_W-1:0] flagsM;
  logic               setFlagsM;
  logic               setFlagsW;

  ctrlBusIf decBus();   // Decode bundle

  decodeStage decodeStage_inst (
    .instrD  (instrD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .bus     (decBus.src)
  );

  executeStage executeStage_inst (
    .clk           (clk),
    .rstN          (rstN),
    .stall         (stall),
    .flushE        (flushE),
    .decBus        (decBus.snk),
    .aluFlagsE     (aluFlagsE),
    .aluResultLowE (aluResultLowE),
    .flagsM        (flagsM),
    .setFlagsM     (setFlagsM),
    .flagsW        (flagsW),
    .setFlagsW     (setFlagsW),
    .aluControlE   (aluControlE),
    .aluSrcE       (aluSrcE),
    .branchTakenE  (branchTakenE),
    .regWriteE     (regWriteE),
    .memWriteE     (memWriteE),
    .memtoRegE     (memtoRegE),
    .pcSrcE        (pcSrcE),
    .setFlagsE     (setFlagsE),
    .flagsNextE    (flagsNextE),
    .byteMaskE     (byteMaskE)
  );

  memWbStage memWbStage_inst (
    .clk        (clk),
    .rstN       (rstN),
    .stall      (stall),
    .regWriteE  (regWriteE),
    .memWriteE  (memWriteE),
    .memtoRegE  (memtoRegE),
    .pcSrcE     (pcSrcE),
    .setFlagsE  (setFlagsE),
    .flagsNextE (flagsNextE),
    .byteMaskE  (byteMaskE),
    .memWriteM  (memWriteM),
    .byteMaskM  (byteMaskM),
    .regWriteW  (regWriteW),
    .memtoRegW  (memtoRegW),
    .pcSrcW     (pcSrcW),
    .flagsM     (flagsM),
    .setFlagsM  (setFlagsM),
    .setFlagsW  (setFlagsW),
    .flagsW     (flagsW)
  );

endmodule

`default_nettype wire

// ==== tbArmController.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_settings.svh"

module tbArmController;

  localparam logic [31:0] nopInstr = 32'hF1A0_0000;  // MOV with NV, never executes
  localparam logic [3:0]  condAl   = 4'hE;

  logic                clk;
  logic                rstN;
  logic                stall;
  logic                flushE;
  logic [`INSTR_W-1:0] instrD;
  logic [`FLAG_W-1:0]  aluFlagsE;
  logic [`OFFS_W-1:0]  aluResultLowE;
  logic [1:0]          regSrcD;
  logic [1:0]          immSrcD;
  armCtrlPkg::aluOpT   aluControlE;
  logic                aluSrcE;
  logic                branchTakenE;
  logic                memWriteM;
  logic [`LANE_W-1:0]  byteMaskM;
  logic                regWriteW;
  logic                memtoRegW;
  logic                pcSrcW;
  logic [`FLAG_W-1:0]  flagsW;

  integer seed;
  int     errorCount;
  int     stallErrors;      // Bumped by the stall property only
  int     errorsAtStart;
  int     passCount;
  int     failCount;
  logic   holdReset;

  // ======================================================================
  // Reference model state, one bundle per stage
  // ======================================================================
  logic       eOpKnown;     // DP or memory op in Execute
  logic       eRw;
  logic       eMw;
  logic       eM2r;
  logic       eBr;
  logic       eAluSrc;      // Immediate or offset operand
  logic [1:0] eFw;          // [1] NZ, [0] CV
  logic [3:0] eOp;
  logic       eByte;
  logic       eStore;
  logic [3:0] eCond;
  logic       mRw;
  logic       mMw;
  logic       mM2r;
  logic       mPc;
  logic       mSf;
  logic [3:0] mFn;
  logic [3:0] mMask;
  logic       wRw;
  logic       wM2r;
  logic       wPc;
  logic       wSf;
  logic [3:0] wFn;
  logic [3:0] modelFlags;   // Committed NZCV

  armController armController_inst (
    .clk(clk), .rstN(rstN), .stall(stall), .flushE(flushE), .instrD(instrD),
    .aluFlagsE(aluFlagsE), .aluResultLowE(aluResultLowE), .regSrcD(regSrcD),
    .immSrcD(immSrcD), .aluControlE(aluControlE), .aluSrcE(aluSrcE),
    .branchTakenE(branchTakenE), .memWriteM(memWriteM), .byteMaskM(byteMaskM),
    .regWriteW(regWriteW), .memtoRegW(memtoRegW), .pcSrcW(pcSrcW), .flagsW(flagsW)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Frozen pipeline keeps every output
  assert property (@(posedge clk) disable iff (!rstN)
      stall |=> $stable({aluControlE, aluSrcE, branchTakenE, memWriteM, byteMaskM,
                         regWriteW, memtoRegW, pcSrcW, flagsW}))
    else begin
      stallErrors++;
      $display("MISMATCH at %0t ns: outputs changed across a stalled cycle", $time);
    end

  // ======================================================================
  // Instruction builders and ARM rules
  // ======================================================================
  function automatic logic [31:0] dpInstr(input logic [3:0] cond, input logic [3:0] op,
                                          input logic s, input logic imm);
    // Compares always carry S
    dpInstr = {cond, 2'b00, imm, op, s | (op[3:2] == 2'b10), 4'h1, 4'h2, 12'h003};
  endfunction

  function automatic logic [31:0] memInstr(input logic [3:0] cond, input logic load,
                                           input logic byteOp, input logic up);
    memInstr = {cond, 3'b010, 1'b1, up, byteOp, 1'b0, load, 4'h1, 4'h2, 12'h004};
  endfunction

  function automatic logic [31:0] brInstr(input logic [3:0] cond);
    brInstr = {cond, 3'b101, 1'b0, 24'h000010};  // Forward branch
  endfunction

  function automatic logic isArith(input logic [3:0] op);
    isArith = (op >= 4'h2 && op <= 4'h7) || (op == 4'hA) || (op == 4'hB);
  endfunction

  function automatic logic passes(input logic [3:0] cond, input logic [3:0] f);
    logic n;
    logic z;
    logic c;
    logic v;
    n = f[`FLAG_N];
    z = f[`FLAG_Z];
    c = f[`FLAG_C];
    v = f[`FLAG_V];
    case (cond)
      4'h0:    passes = z;
      4'h1:    passes = !z;
      4'h2:    passes = c;
      4'h3:    passes = !c;
      4'h4:    passes = n;
      4'h5:    passes = !n;
      4'h6:    passes = v;
      4'h7:    passes = !v;
      4'h8:    passes = c && !z;
      4'h9:    passes = !c || z;
      4'hA:    passes = (n == v);
      4'hB:    passes = (n != v);
      4'hC:    passes = !z && (n == v);
      4'hD:    passes = z || (n != v);
      4'hE:    passes = 1'b1;
      default: passes = 1'b0;       // NV
    endcase
  endfunction

  task automatic bubbleExecute();
    eOpKnown = 1'b0;
    eRw = 1'b0;
    eMw = 1'b0;
    eM2r = 1'b0;
    eBr = 1'b0;
    eAluSrc = 1'b0;
    eFw = 2'b00;
    eByte = 1'b0;
    eStore = 1'b0;
    eCond = condAl;
  endtask

  task automatic loadExecute(input logic [31:0] instr);
    logic [3:0] op;
    logic       isDp;
    logic       isMem;
    logic       isCmp;
    op    = instr[24:21];
    isDp  = (instr[27:26] == 2'b00);
    isMem = (instr[27:26] == 2'b01);
    isCmp = isDp && (op[3:2] == 2'b10);
    eOpKnown = isDp || isMem;
    eRw    = (isDp && !isCmp) || (isMem && instr[20]);
    eMw    = isMem && !instr[20];
    eM2r   = isMem && instr[20];
    eBr    = (instr[27:25] == 3'b101);
    eAluSrc = isDp ? instr[25] : (isMem ? !instr[25] : eBr);  // I=0 means offset imm
    eFw    = (isDp && instr[20]) ? {1'b1, isArith(op)} : 2'b00;
    eOp    = isDp ? op : (instr[23] ? 4'h4 : 4'h2);   // ADD when U set
    eByte  = isMem && instr[22];
    eStore = eMw;
    eCond  = instr[31:28];
  endtask

  task automatic resetModel();
    bubbleExecute();
    {mRw, mMw, mM2r, mPc, mSf, mFn, mMask} = '0;
    {wRw, wM2r, wPc, wSf, wFn} = '0;
    modelFlags = 4'h0;
  endtask

  task automatic expectEq(input string what, input logic [3:0] got, input logic [3:0] exp);
    assert (got == exp) else begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // ======================================================================
  // One clock cycle: drive, check, advance the model
  // ======================================================================
  task automatic stepCycle(input logic [31:0] instr, input logic [3:0] aluFl,
                           input logic [1:0] offs, input logic stallIn, input logic flushIn);
    logic [3:0] fwd;
    logic       ok;
    logic       rwE;
    logic       mwE;
    logic       brE;
    logic       sfE;
    logic [3:0] fnE;
    logic [3:0] maskE;
    logic       isBrD;
    logic       isMemD;
    @(negedge clk);
    rstN          = !holdReset;
    instrD        = instr;
    aluFlagsE     = aluFl;
    aluResultLowE = offs;
    stall         = stallIn;
    flushE        = flushIn;
    #10;                                               // Outputs settled
    isBrD  = (instr[27:25] == 3'b101);
    isMemD = (instr[27:26] == 2'b01);
    // Rd read for STR, PC read for B
    expectEq("regSrcD", 4'(regSrcD), {2'b00, isMemD && !instr[20], isBrD});
    expectEq("immSrcD", 4'(immSrcD), isBrD ? 4'd2 : (isMemD ? 4'd1 : 4'd0));
    fwd = mSf ? mFn : (wSf ? wFn : modelFlags);        // Youngest pending wins
    ok  = passes(eCond, fwd);
    rwE = eRw & ok;
    mwE = eMw & ok;
    brE = eBr & ok;
    sfE = (eFw != 2'b00) & ok;
    fnE = fwd;
    if (eFw[1]) begin
      fnE[`FLAG_N] = aluFl[`FLAG_N];
      fnE[`FLAG_Z] = aluFl[`FLAG_Z];
    end
    if (eFw[0]) begin
      fnE[`FLAG_C] = aluFl[`FLAG_C];
      fnE[`FLAG_V] = aluFl[`FLAG_V];
    end
    maskE = (eStore && mwE) ? (eByte ? (4'b0001 << offs) : 4'b1111) : 4'b0000;
    if (eOpKnown)
      expectEq("aluControlE", 4'(aluControlE), eOp);
    if (eOpKnown || eBr)
      expectEq("aluSrcE", 4'(aluSrcE), 4'(eAluSrc));
    expectEq("branchTakenE", 4'(branchTakenE), 4'(brE));
    expectEq("memWriteM", 4'(memWriteM), 4'(mMw));
    expectEq("byteMaskM", byteMaskM, mMask);
    expectEq("regWriteW", 4'(regWriteW), 4'(wRw));
    expectEq("memtoRegW", 4'(memtoRegW), 4'(wM2r));
    expectEq("pcSrcW", 4'(pcSrcW), 4'(wPc));
    expectEq("flagsW", flagsW, modelFlags);
    if (holdReset) begin
      resetModel();
    end else if (!stallIn) begin
      if (wSf)
        modelFlags = wFn;                              // Commit from W bundle
      {wRw, wM2r, wPc, wSf, wFn} = {mRw, mM2r, mPc, mSf, mFn};
      {mRw, mMw, mM2r, mPc, mSf, mFn, mMask} = {rwE, mwE, eM2r, brE, sfE, fnE, maskE};
      if (flushIn)
        bubbleExecute();
      else
        loadExecute(instr);
    end
  endtask

  task automatic drain();
    repeat (4) stepCycle(nopInstr, 4'h0, 2'd0, 1'b0, 1'b0);
  endtask

  task automatic startTest();
    errorsAtStart = errorCount + stallErrors;
  endtask

  task automatic endTest(input string name);
    int found;
    found = errorCount + stallErrors - errorsAtStart;
    if (found == 0)
      passCount++;
    else
      failCount++;
    $display("Test %s: %s (%0d mismatches)", name, (found == 0) ? "ok" : "FAILED", found);
  endtask

  // ======================================================================
  // Tests
  // ======================================================================
  task automatic resetTest();
    startTest();
    repeat (3) stepCycle(nopInstr, 4'hF, 2'd3, 1'b0, 1'b0);  // Reset held 4 edges
    holdReset = 1'b0;
    repeat (2) stepCycle(nopInstr, 4'h0, 2'd0, 1'b0, 1'b0);
    endTest("reset");
  endtask

  task automatic dataProcTest();
    logic [31:0] r;
    startTest();
    repeat (24) begin
      r = $random(seed);
      stepCycle(dpInstr(condAl, r[3:0], r[4], r[5]), r[11:8], 2'd0, 1'b0, 1'b0);
    end
    drain();
    endTest("data processing");
  endtask

  task automatic condExecTest();
    logic [31:0] r;
    logic [31:0] instr;
    startTest();
    repeat (40) begin
      r = $random(seed);
      case (r[1:0])
        2'd2:    instr = memInstr(r[7:4], 1'b0, r[19], 1'b1);
        2'd3:    instr = brInstr(r[7:4]);
        default: instr = dpInstr(r[7:4], r[11:8], 1'b1, r[18]);  // Flag setters
      endcase
      stepCycle(instr, r[15:12], r[17:16], 1'b0, 1'b0);
    end
    drain();
    endTest("conditional execution");
  endtask

  task automatic memAccessTest();
    logic [31:0] r;
    startTest();
    stepCycle(memInstr(condAl, 1'b0, 1'b0, 1'b1), 4'h0, 2'd1, 1'b0, 1'b0);  // STR
    repeat (8) begin
      r = $random(seed);
      stepCycle(memInstr(condAl, 1'b0, 1'b1, r[2]), 4'h0, r[1:0], 1'b0, 1'b0);  // STRB
      stepCycle(memInstr(condAl, 1'b1, r[3], r[4]), 4'h0, r[6:5], 1'b0, 1'b0);  // LDR/LDRB
    end
    drain();
    endTest("loads and stores");
  endtask

  task automatic branchTest();
    int cycles;
    startTest();
    stepCycle(brInstr(condAl), 4'h0, 2'd0, 1'b0, 1'b0);
    cycles = 0;
    while (!pcSrcW && cycles < 8) begin
      stepCycle(nopInstr, 4'h0, 2'd0, 1'b0, 1'b0);
      cycles++;
    end
    if (!pcSrcW) begin
      errorCount++;
      $display("Timeout at %0t ns: pcSrcW never rose after a taken branch", $time);
    end else begin
      expectEq("branch to pcSrcW latency", 4'(cycles), 4'd3);
    end
    drain();
    stepCycle(dpInstr(condAl, 4'hA, 1'b1, 1'b0), 4'b0100, 2'd0, 1'b0, 1'b0);  // CMP sets Z
    stepCycle(brInstr(4'h1), 4'h0, 2'd0, 1'b0, 1'b0);                        // BNE falls through
    stepCycle(brInstr(4'h0), 4'h0, 2'd0, 1'b0, 1'b0);                        // BEQ taken
    stepCycle(brInstr(4'hF), 4'h0, 2'd0, 1'b0, 1'b0);                        // NV
    drain();
    endTest("branch");
  endtask

  task automatic stallFlushTest();
    logic [31:0] r;
    startTest();
    stepCycle(dpInstr(condAl, 4'h4, 1'b1, 1'b0), 4'b1010, 2'd0, 1'b0, 1'b0);
    stepCycle(brInstr(condAl), 4'h0, 2'd0, 1'b0, 1'b0);
    repeat (3) begin
      r = $random(seed);
      stepCycle(dpInstr(condAl, r[3:0], 1'b1, 1'b0), r[7:4], r[9:8], 1'b1, 1'b0);
    end
    stepCycle(dpInstr(condAl, 4'h2, 1'b1, 1'b1), 4'b1111, 2'd0, 1'b0, 1'b1);  // Flushed SUBS
    stepCycle(brInstr(condAl), 4'h0, 2'd0, 1'b0, 1'b1);                      // Flushed B
    stepCycle(memInstr(condAl, 1'b0, 1'b1, 1'b1), 4'h0, 2'd2, 1'b1, 1'b1);   // Stall wins
    stepCycle(memInstr(condAl, 1'b0, 1'b1, 1'b1), 4'h0, 2'd2, 1'b0, 1'b0);
    drain();
    endTest("stall and flush");
  endtask

  initial begin
    seed          = 32'h4b15;
    errorCount    = 0;
    stallErrors   = 0;
    passCount     = 0;
    failCount     = 0;
    holdReset     = 1'b1;
    rstN          = 1'b0;
    stall         = 1'b0;
    flushE        = 1'b0;
    instrD        = nopInstr;
    aluFlagsE     = 4'h0;
    aluResultLowE = 2'd0;
    resetModel();
    resetTest();
    dataProcTest();
    condExecTest();
    memAccessTest();
    branchTest();
    stallFlushTest();
    $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
             passCount, failCount, errorCount + stallErrors);
    if (errorCount + stallErrors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
armCtrlPkg.sv
ctrlBusIf.sv
decodeStage.sv
condCheck.sv
executeStage.sv
memWbStage.sv
armController.sv
tbArmController.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbArmController -f project.f

out=$(./obj_dir/VtbArmController)
echo "$out"

# Exit status comes from the search
echo "$out" | grep -qx "Simulation finished: PASS"
